//--- flist.f
logic/noc_tile_pkg.sv
logic/wake_up_timer.sv
logic/tile_sync.sv
logic/noc_bridge_fsm.sv
logic/noc_flit_packer.sv
logic/noc_resp_unpacker.sv
logic/noc_tile_wrap.sv
sim/tb_noc_tile_wrap.sv

//--- sim/tb_noc_tile_wrap.sv
`timescale 1ns/10ps

module tb_noc_tile_wrap;

  localparam int max_cycles = 3000;

  logic                                    clk_i;
  logic                                    reset_l;
  logic [noc_tile_pkg::coord_width-1:0]    src_x_i;
  logic [noc_tile_pkg::coord_width-1:0]    src_y_i;
  noc_tile_pkg::tile_irq_t                 irq_async_i;
  noc_tile_pkg::tile_irq_t                 irq_o;
  logic                                    tile_rst_l_o;
  noc_tile_pkg::wb_req_t                   wb_req_i;
  noc_tile_pkg::wb_rsp_t                   wb_rsp_o;
  logic                                    noc1_valid_o;
  logic [noc_tile_pkg::noc_data_width-1:0] noc1_data_o;
  logic                                    noc1_ready_i;
  logic                                    noc2_valid_i;
  logic [noc_tile_pkg::noc_data_width-1:0] noc2_data_i;
  logic                                    noc2_ready_o;
  int                                      cycle_cnt = 0;

  noc_tile_wrap #(
    .wake_cnt_width (4)
  ) uut (
    .clk_i        (clk_i),
    .reset_l      (reset_l),
    .src_x_i      (src_x_i),
    .src_y_i      (src_y_i),
    .irq_async_i  (irq_async_i),
    .irq_o        (irq_o),
    .tile_rst_l_o (tile_rst_l_o),
    .wb_req_i     (wb_req_i),
    .wb_rsp_o     (wb_rsp_o),
    .noc1_valid_o (noc1_valid_o),
    .noc1_data_o  (noc1_data_o),
    .noc1_ready_i (noc1_ready_i),
    .noc2_valid_i (noc2_valid_i),
    .noc2_data_i  (noc2_data_i),
    .noc2_ready_o (noc2_ready_o)
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      $display("timeout: the run went past %0d cycles without finishing", max_cycles);
      $display("Errors found");
      $fatal(1, "simulation stopped on timeout");
    end
  end

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("error: %s expected %h actual %h", name, exp, act);
      $display("Errors found");
      $fatal(1, "value mismatch");
    end
  endtask

  ////////////////////
  // expected flits
  ////////////////////

  function automatic logic [63:0] req_hdr(input logic we, input logic [7:0] tag);
    noc_tile_pkg::noc_header_t h;
    h.dst_x       = noc_tile_pkg::l2_dest_x;
    h.dst_y       = noc_tile_pkg::l2_dest_y;
    h.dst_fbits   = noc_tile_pkg::l2_fbits;
    h.payload_len = we ? 8'd2 : 8'd1;
    h.msg_type    = we ? noc_tile_pkg::store_req : noc_tile_pkg::load_req;
    h.mshr        = tag;
    h.reserved    = '0;
    return h;
  endfunction

  function automatic logic [63:0] addr_flit(input logic [39:0] adr);
    noc_tile_pkg::noc_addr_flit_t a;
    a.addr      = adr;
    a.src_x     = src_x_i;
    a.src_y     = src_y_i;
    a.src_fbits = noc_tile_pkg::tile_fbits;
    a.reserved  = '0;
    return a;
  endfunction

  // response headers head back to this tile
  function automatic logic [63:0] rsp_hdr(input noc_tile_pkg::noc_msg_e msg,
                                          input logic [7:0] tag, input logic [7:0] len);
    noc_tile_pkg::noc_header_t h;
    h.dst_x       = src_x_i;
    h.dst_y       = src_y_i;
    h.dst_fbits   = noc_tile_pkg::tile_fbits;
    h.payload_len = len;
    h.msg_type    = msg;
    h.mshr        = tag;
    h.reserved    = '0;
    return h;
  endfunction

  ////////////////////
  // bus and noc models
  ////////////////////

  task automatic drive_req(input logic we, input logic [39:0] adr, input logic [63:0] wdat);
    noc_tile_pkg::wb_req_t req;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.adr = adr;
    req.dat = wdat;
    req.sel = 8'hff;
    wb_req_i <= req;
  endtask

  // waits for one noc1 transfer with random ready under back-pressure
  task automatic take_flit(input logic bp, output logic [63:0] flit);
    logic        got;
    logic [31:0] rnd;
    got = 1'b0;
    while (!got) begin
      @(posedge clk_i);
      if (noc1_valid_o && noc1_ready_i) begin
        flit = noc1_data_o;
        got  = 1'b1;
      end
      rnd = $urandom;
      noc1_ready_i <= bp ? rnd[0] : 1'b1;
    end
  endtask

  task automatic give_flit(input logic [63:0] flit);
    logic got;
    got = 1'b0;
    noc2_valid_i <= 1'b1;
    noc2_data_i  <= flit;
    while (!got) begin
      @(posedge clk_i);
      got = noc2_valid_i && noc2_ready_o;
    end
    noc2_valid_i <= 1'b0;
  endtask

  // ack or err is due one cycle after the last response flit
  task automatic finish_cycle(input string name, input logic exp_ack,
                              input logic check_dat, input logic [63:0] exp_dat);
    int waited;
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
    end while (!(wb_rsp_o.ack || wb_rsp_o.err));
    check({name, " response latency"}, 64'd1, waited);
    check({name, " ack"}, exp_ack, wb_rsp_o.ack);
    check({name, " err"}, !exp_ack, wb_rsp_o.err);
    if (check_dat) begin
      check({name, " read data"}, exp_dat, wb_rsp_o.dat);
    end
    wb_req_i <= '0;
    @(posedge clk_i);
    check({name, " ack after end"}, 64'd0, wb_rsp_o.ack);
    check({name, " err after end"}, 64'd0, wb_rsp_o.err);
  endtask

  task automatic run_txn(input string name, input logic we, input logic [39:0] adr,
                         input logic [63:0] wdat, input logic bp, input logic [7:0] exp_tag,
                         input noc_tile_pkg::noc_msg_e rsp_msg, input logic [7:0] rsp_tag,
                         input logic exp_ack);
    logic [63:0] flit;
    logic [63:0] rd_flit;
    drive_req(we, adr, wdat);
    take_flit(bp, flit);
    check({name, " header flit"}, req_hdr(we, exp_tag), flit);
    take_flit(bp, flit);
    check({name, " address flit"}, addr_flit(adr), flit);
    if (we) begin
      take_flit(bp, flit);
      check({name, " data flit"}, wdat, flit);
    end
    give_flit(rsp_hdr(rsp_msg, rsp_tag, we ? 8'd0 : 8'd1));
    rd_flit = {$urandom, $urandom};
    if (!we) begin
      give_flit(rd_flit);
    end
    finish_cycle(name, exp_ack, !we && exp_ack, rd_flit);
  endtask

  ////////////////////
  // directed tests
  ////////////////////

  // the write request goes out while the tile is still held in reset
  task automatic test_wake_up();
    int i;
    reset_l <= 1'b1;
    drive_req(1'b1, 40'h12_3456_7890, 64'h0123_4567_89ab_cdef);
    for (i = 0; i < 10; i++) begin
      @(posedge clk_i);
      check("wake_up tile reset low", 64'd0, tile_rst_l_o);
      check("wake_up noc1 valid", 64'd0, noc1_valid_o);
      check("wake_up noc2 ready", 64'd0, noc2_ready_o);
      check("wake_up ack", 64'd0, wb_rsp_o.ack);
    end
    @(posedge clk_i);
    check("wake_up tile reset high", 64'd1, tile_rst_l_o);
    check("wake_up noc1 valid at release", 64'd0, noc1_valid_o);
  endtask

  task automatic test_write();
    run_txn("write", 1'b1, 40'h12_3456_7890, 64'h0123_4567_89ab_cdef, 1'b0,
            8'd0, noc_tile_pkg::store_ack, 8'd0, 1'b1);
  endtask

  task automatic test_read_backpressure();
    run_txn("read_bp", 1'b0, 40'h00_0000_1f40, 64'd0, 1'b1,
            8'd1, noc_tile_pkg::load_ack, 8'd1, 1'b1);
    noc1_ready_i <= 1'b0;
  endtask

  task automatic test_mismatch();
    run_txn("bad_tag", 1'b0, 40'h80_0000_0100, 64'd0, 1'b0,
            8'd2, noc_tile_pkg::load_ack, 8'd7, 1'b0);
    run_txn("bad_type", 1'b1, 40'h80_0000_0108, 64'h5555_aaaa_5555_aaaa, 1'b0,
            8'd3, noc_tile_pkg::load_ack, 8'd3, 1'b0);
    // tag keeps counting past both errors
    run_txn("after_err", 1'b0, 40'h80_0000_0110, 64'd0, 1'b0,
            8'd4, noc_tile_pkg::load_ack, 8'd4, 1'b1);
  endtask

  task automatic irq_step(input string name, input noc_tile_pkg::tile_irq_t value);
    noc_tile_pkg::tile_irq_t prev;
    prev = irq_async_i;
    irq_async_i <= value;
    @(posedge clk_i);
    check({name, " cycle 1"}, prev, irq_o);
    @(posedge clk_i);
    check({name, " cycle 2"}, prev, irq_o);
    @(posedge clk_i);
    check({name, " cycle 3"}, value, irq_o);
  endtask

  task automatic test_irq();
    int b;
    repeat (3) @(posedge clk_i);
    for (b = 0; b < 5; b++) begin
      irq_step($sformatf("irq bit %0d set", b), noc_tile_pkg::tile_irq_t'(5'b00001 << b));
      irq_step($sformatf("irq bit %0d clear", b), '0);
    end
  endtask

  initial begin
    void'($urandom(32'h3244_4cbd));
    reset_l      = 1'b0;
    src_x_i      = 8'd3;
    src_y_i      = 8'd5;
    irq_async_i  = '0;
    wb_req_i     = '0;
    noc1_ready_i = 1'b0;
    noc2_valid_i = 1'b0;
    noc2_data_i  = '0;
    repeat (5) @(posedge clk_i);
    test_wake_up();
    test_write();
    test_read_backpressure();
    test_mismatch();
    test_irq();
    check("tile reset still high", 64'd1, tile_rst_l_o);
    $display("No errors");
    $finish;
  end

endmodule

//--- logic/noc_tile_wrap.sv
`timescale 1ns/10ps

module noc_tile_wrap #(
  parameter int wake_cnt_width = 16
) (
  input  logic                                    clk_i,
  input  logic                                    reset_l,
  input  logic [noc_tile_pkg::coord_width-1:0]    src_x_i,
  input  logic [noc_tile_pkg::coord_width-1:0]    src_y_i,
  input  noc_tile_pkg::tile_irq_t                 irq_async_i,
  output noc_tile_pkg::tile_irq_t                 irq_o,
  output logic                                    tile_rst_l_o,
  input  noc_tile_pkg::wb_req_t                   wb_req_i,
  output noc_tile_pkg::wb_rsp_t                   wb_rsp_o,
  output logic                                    noc1_valid_o,
  output logic [noc_tile_pkg::noc_data_width-1:0] noc1_data_o,
  input  logic                                    noc1_ready_i,
  input  logic                                    noc2_valid_i,
  input  logic [noc_tile_pkg::noc_data_width-1:0] noc2_data_i,
  output logic                                    noc2_ready_o
);

  logic                                    wake_done;
  noc_tile_pkg::bridge_state_e             flit_sel;
  logic                                    tag_advance;
  logic                                    hdr_capture;
  logic                                    data_capture;
  logic                                    resp_ok;
  logic                                    wb_ack;
  logic                                    wb_err;
  logic [7:0]                              req_tag;
  logic [noc_tile_pkg::noc_data_width-1:0] rd_data;

  ////////////////////
  // reset and sync
  ////////////////////

  wake_up_timer #(
    .wake_cnt_width (wake_cnt_width)
  ) i_wake_up_timer (
    .clk_i       (clk_i),
    .reset_l     (reset_l),
    .wake_done_o (wake_done)
  );

  tile_sync i_tile_sync (
    .clk_i        (clk_i),
    .reset_l      (reset_l),
    .wake_done_i  (wake_done),
    .irq_async_i  (irq_async_i),
    .tile_rst_l_o (tile_rst_l_o),
    .irq_o        (irq_o)
  );

  ////////////////////
  // noc bridge
  ////////////////////

  // bridge runs on the synchronized tile reset
  noc_bridge_fsm i_noc_bridge_fsm (
    .clk_i          (clk_i),
    .rst_l_i        (tile_rst_l_o),
    .wb_cyc_i       (wb_req_i.cyc),
    .wb_stb_i       (wb_req_i.stb),
    .wb_we_i        (wb_req_i.we),
    .noc1_ready_i   (noc1_ready_i),
    .noc2_valid_i   (noc2_valid_i),
    .resp_ok_i      (resp_ok),
    .flit_sel_o     (flit_sel),
    .noc1_valid_o   (noc1_valid_o),
    .noc2_ready_o   (noc2_ready_o),
    .hdr_capture_o  (hdr_capture),
    .data_capture_o (data_capture),
    .tag_advance_o  (tag_advance),
    .wb_ack_o       (wb_ack),
    .wb_err_o       (wb_err)
  );

  noc_flit_packer i_noc_flit_packer (
    .clk_i         (clk_i),
    .rst_l_i       (tile_rst_l_o),
    .wb_req_i      (wb_req_i),
    .flit_sel_i    (flit_sel),
    .tag_advance_i (tag_advance),
    .src_x_i       (src_x_i),
    .src_y_i       (src_y_i),
    .noc1_data_o   (noc1_data_o),
    .req_tag_o     (req_tag)
  );

  noc_resp_unpacker i_noc_resp_unpacker (
    .clk_i          (clk_i),
    .rst_l_i        (tile_rst_l_o),
    .noc2_data_i    (noc2_data_i),
    .hdr_capture_i  (hdr_capture),
    .data_capture_i (data_capture),
    .wb_we_i        (wb_req_i.we),
    .req_tag_i      (req_tag),
    .resp_ok_o      (resp_ok),
    .rd_data_o      (rd_data)
  );

  assign wb_rsp_o.ack = wb_ack;
  assign wb_rsp_o.err = wb_err;
  assign wb_rsp_o.dat = rd_data;

endmodule

//--- logic/noc_resp_unpacker.sv
`timescale 1ns/10ps

module noc_resp_unpacker (
  input  logic                                    clk_i,
  input  logic                                    rst_l_i,
  input  logic [noc_tile_pkg::noc_data_width-1:0] noc2_data_i,
  input  logic                                    hdr_capture_i,
  input  logic                                    data_capture_i,
  input  logic                                    wb_we_i,
  input  logic [7:0]                              req_tag_i,
  output logic                                    resp_ok_o,
  output logic [noc_tile_pkg::noc_data_width-1:0] rd_data_o
);

  noc_tile_pkg::noc_header_t               hdr;
  noc_tile_pkg::noc_msg_e                  exp_msg;
  logic                                    hdr_match;
  logic                                    resp_ok_q;
  logic [noc_tile_pkg::noc_data_width-1:0] rd_data_q;

  assign hdr       = noc_tile_pkg::noc_header_t'(noc2_data_i);
  assign exp_msg   = wb_we_i ? noc_tile_pkg::store_ack : noc_tile_pkg::load_ack;
  // type and tag must both agree with the outstanding request
  assign hdr_match = (hdr.msg_type == exp_msg) && (hdr.mshr == req_tag_i);

  always_ff @(posedge clk_i or negedge rst_l_i) begin
    if (!rst_l_i) begin
      resp_ok_q <= 1'b0;
    end else if (hdr_capture_i) begin
      resp_ok_q <= hdr_match;
    end
  end

  // read data flit held until the next read
  always_ff @(posedge clk_i) begin
    if (data_capture_i) begin
      rd_data_q <= noc2_data_i;
    end
  end

  assign resp_ok_o = resp_ok_q;
  assign rd_data_o = rd_data_q;

endmodule

//--- logic/noc_flit_packer.sv
`timescale 1ns/10ps

module noc_flit_packer (
  input  logic                                     clk_i,
  input  logic                                     rst_l_i,
  input  noc_tile_pkg::wb_req_t                    wb_req_i,
  input  noc_tile_pkg::bridge_state_e              flit_sel_i,
  input  logic                                     tag_advance_i,
  input  logic [noc_tile_pkg::coord_width-1:0]     src_x_i,
  input  logic [noc_tile_pkg::coord_width-1:0]     src_y_i,
  output logic [noc_tile_pkg::noc_data_width-1:0]  noc1_data_o,
  output logic [7:0]                               req_tag_o
);

  logic [7:0]                   tag_q;
  noc_tile_pkg::noc_header_t    hdr;
  noc_tile_pkg::noc_addr_flit_t addr_flit;

  // mshr tag wraps after 255
  always_ff @(posedge clk_i or negedge rst_l_i) begin
    if (!rst_l_i) begin
      tag_q <= '0;
    end else if (tag_advance_i) begin
      tag_q <= tag_q + 8'd1;
    end
  end

  assign req_tag_o = tag_q;

  ////////////////////
  // flit build
  ////////////////////

  assign hdr.dst_x       = noc_tile_pkg::l2_dest_x;
  assign hdr.dst_y       = noc_tile_pkg::l2_dest_y;
  assign hdr.dst_fbits   = noc_tile_pkg::l2_fbits;
  assign hdr.payload_len = wb_req_i.we ? 8'd2 : 8'd1;
  assign hdr.msg_type    = wb_req_i.we ? noc_tile_pkg::store_req : noc_tile_pkg::load_req;
  assign hdr.mshr        = tag_q;
  assign hdr.reserved    = '0;

  assign addr_flit.addr      = wb_req_i.adr;
  assign addr_flit.src_x     = src_x_i;
  assign addr_flit.src_y     = src_y_i;
  assign addr_flit.src_fbits = noc_tile_pkg::tile_fbits;
  assign addr_flit.reserved  = '0;

  always_comb begin
    case (flit_sel_i)
      noc_tile_pkg::send_hdr:  noc1_data_o = hdr;
      noc_tile_pkg::send_addr: noc1_data_o = addr_flit;
      noc_tile_pkg::send_data: noc1_data_o = wb_req_i.dat;
      default:                 noc1_data_o = '0;
    endcase
  end

endmodule

//--- logic/noc_bridge_fsm.sv
`timescale 1ns/10ps

module noc_bridge_fsm (
  input  logic                        clk_i,
  input  logic                        rst_l_i,
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  logic                        noc1_ready_i,
  input  logic                        noc2_valid_i,
  input  logic                        resp_ok_i,
  output noc_tile_pkg::bridge_state_e flit_sel_o,
  output logic                        noc1_valid_o,
  output logic                        noc2_ready_o,
  output logic                        hdr_capture_o,
  output logic                        data_capture_o,
  output logic                        tag_advance_o,
  output logic                        wb_ack_o,
  output logic                        wb_err_o
);

  noc_tile_pkg::bridge_state_e state_q;
  noc_tile_pkg::bridge_state_e state_d;

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      noc_tile_pkg::idle: begin
        if (wb_cyc_i && wb_stb_i) begin
          state_d = noc_tile_pkg::send_hdr;
        end
      end
      noc_tile_pkg::send_hdr: begin
        if (noc1_ready_i) begin
          state_d = noc_tile_pkg::send_addr;
        end
      end
      noc_tile_pkg::send_addr: begin
        if (noc1_ready_i) begin
          state_d = wb_we_i ? noc_tile_pkg::send_data : noc_tile_pkg::wait_hdr;
        end
      end
      noc_tile_pkg::send_data: begin
        if (noc1_ready_i) begin
          state_d = noc_tile_pkg::wait_hdr;
        end
      end
      noc_tile_pkg::wait_hdr: begin
        // a read always drains its data flit, even on a bad header
        if (noc2_valid_i) begin
          state_d = wb_we_i ? noc_tile_pkg::done : noc_tile_pkg::wait_data;
        end
      end
      noc_tile_pkg::wait_data: begin
        if (noc2_valid_i) begin
          state_d = noc_tile_pkg::done;
        end
      end
      noc_tile_pkg::done: begin
        state_d = noc_tile_pkg::idle;
      end
      default: begin
        state_d = noc_tile_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_l_i) begin
    if (!rst_l_i) begin
      state_q <= noc_tile_pkg::idle;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////
  // outputs
  ////////////////////

  assign flit_sel_o     = state_q;
  assign noc1_valid_o   = (state_q == noc_tile_pkg::send_hdr) ||
                          (state_q == noc_tile_pkg::send_addr) ||
                          (state_q == noc_tile_pkg::send_data);
  assign noc2_ready_o   = (state_q == noc_tile_pkg::wait_hdr) ||
                          (state_q == noc_tile_pkg::wait_data);
  assign hdr_capture_o  = (state_q == noc_tile_pkg::wait_hdr) && noc2_valid_i;
  assign data_capture_o = (state_q == noc_tile_pkg::wait_data) && noc2_valid_i;

  // one cycle pulse ends the wishbone cycle
  assign tag_advance_o  = (state_q == noc_tile_pkg::done);
  assign wb_ack_o       = (state_q == noc_tile_pkg::done) && resp_ok_i;
  assign wb_err_o       = (state_q == noc_tile_pkg::done) && !resp_ok_i;

endmodule

//--- logic/tile_sync.sv
`timescale 1ns/10ps

module tile_sync (
  input  logic                    clk_i,
  input  logic                    reset_l,
  input  logic                    wake_done_i,
  input  noc_tile_pkg::tile_irq_t irq_async_i,
  output logic                    tile_rst_l_o,
  output noc_tile_pkg::tile_irq_t irq_o
);

  localparam int irq_width  = $bits(noc_tile_pkg::tile_irq_t);
  localparam int sync_width = irq_width + 1;

  logic [sync_width-1:0] sync_in;
  logic [sync_width-1:0] meta_q;
  logic [sync_width-1:0] sync_q;

  // gated reset sits in the top bit, interrupt lines below it
  assign sync_in = {wake_done_i, irq_async_i};

  ////////////////////
  // two-flop chain
  ////////////////////

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= sync_in;
      sync_q <= meta_q;
    end
  end

  assign tile_rst_l_o = sync_q[sync_width-1];
  assign irq_o        = noc_tile_pkg::tile_irq_t'(sync_q[irq_width-1:0]);

endmodule

//--- logic/wake_up_timer.sv
`timescale 1ns/10ps

module wake_up_timer #(
  parameter int wake_cnt_width = 16
) (
  input  logic clk_i,
  input  logic reset_l,
  output logic wake_done_o
);

  logic [wake_cnt_width-1:0] cnt_q;
  logic [wake_cnt_width-1:0] cnt_d;

  // count up until the top bit is set, then hold there
  always_comb begin
    if (cnt_q[wake_cnt_width-1]) begin
      cnt_d = cnt_q;
    end else begin
      cnt_d = cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // memories are taken as initialized once the top bit is reached
  assign wake_done_o = cnt_q[wake_cnt_width-1];

endmodule

//--- logic/noc_tile_pkg.sv
package noc_tile_pkg;

  // widths
  localparam int noc_data_width = 64;
  localparam int wb_addr_width  = 40;
  localparam int coord_width    = 8;
  localparam int fbits_width    = 4;

  // fixed destination is the L2 home tile at the origin
  localparam logic [coord_width-1:0] l2_dest_x  = 8'd0;
  localparam logic [coord_width-1:0] l2_dest_y  = 8'd0;
  localparam logic [fbits_width-1:0] l2_fbits   = 4'b0000;
  localparam logic [fbits_width-1:0] tile_fbits = 4'b0010;

  typedef enum logic [7:0] {
    load_req  = 8'd14,
    store_req = 8'd15,
    store_ack = 8'd28,
    load_ack  = 8'd29
  } noc_msg_e;

  typedef enum logic [2:0] {
    idle,
    send_hdr,
    send_addr,
    send_data,
    wait_hdr,
    wait_data,
    done
  } bridge_state_e;

  ////////////////////
  // flit formats
  ////////////////////

  typedef struct packed {
    logic [coord_width-1:0] dst_x;
    logic [coord_width-1:0] dst_y;
    logic [fbits_width-1:0] dst_fbits;
    // flits following the header
    logic [7:0]             payload_len;
    noc_msg_e               msg_type;
    logic [7:0]             mshr;
    logic [19:0]            reserved;
  } noc_header_t;

  typedef struct packed {
    logic [wb_addr_width-1:0] addr;
    logic [coord_width-1:0]   src_x;
    logic [coord_width-1:0]   src_y;
    logic [fbits_width-1:0]   src_fbits;
    logic [3:0]               reserved;
  } noc_addr_flit_t;

  ////////////////////
  // wishbone and irq
  ////////////////////

  typedef struct packed {
    logic                      cyc;
    logic                      stb;
    logic                      we;
    logic [wb_addr_width-1:0]  adr;
    logic [noc_data_width-1:0] dat;
    logic [7:0]                sel;
  } wb_req_t;

  typedef struct packed {
    logic                      ack;
    logic                      err;
    logic [noc_data_width-1:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic [1:0] irq;
    logic       ipi;
    logic       time_irq;
    logic       debug_req;
  } tile_irq_t;

endpackage
